//--- design/rx_cfg_pkg.sv
`default_nettype none

package rx_cfg_pkg;

    // Widest word the receiver can capture
    parameter int DATA_W = 32;

    // Frame offset range in bit clocks
    parameter int OFFSET_W = 9;

    // Bit counter and word length field, sized for DATA_W
    parameter int BITS_W = $clog2(DATA_W);

    // Static configuration levels, held for the length of a frame
    typedef struct packed {
        logic                en;
        logic                two_ch;
        logic                lsb_first;
        // Word length minus one
        logic [BITS_W-1:0]   num_bits;
        // Bit clocks between word select and bit 0 of the first word
        logic [OFFSET_W-1:0] offset;
    } rx_cfg_t;

endpackage

`default_nettype wire

//--- design/rx_data_pkg.sv
`default_nettype none

package rx_data_pkg;

    // One word as it leaves on the output stream
    typedef logic [rx_cfg_pkg::DATA_W-1:0] sample_t;

    // Per-edge strobes from the control FSM to both datapaths
    typedef struct packed {
        // This edge samples bit 0 of a word
        logic first;
        // This edge samples any bit of a word
        logic shift;
        // This edge samples the final bit of a word
        logic last;
        // Back to idle, drop everything in flight
        logic clear;
    } bit_strobe_t;

endpackage

`default_nettype wire

//--- design/rx_ctrl.sv
`default_nettype none

module rx_ctrl #(
    parameter int OFFSET_W = rx_cfg_pkg::OFFSET_W
) (
    input  logic                     sck_i,
    input  logic                     rstn_i,
    input  logic                     i2s_ws_i,
    input  rx_cfg_pkg::rx_cfg_t      cfg_i,
    output rx_data_pkg::bit_strobe_t strobe_o
);

    import rx_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        OFFSET,
        RUN
    } state_e;

    state_e              state_q;
    state_e              state_d;
    logic [OFFSET_W-1:0] offset_cnt_q;
    logic [BITS_W-1:0]   bit_cnt_q;
    logic                ws_start;
    logic                offset_done;
    logic                sample;

    // Word select only matters while waiting in IDLE
    assign ws_start    = cfg_i.en && (state_q == IDLE) && i2s_ws_i;
    assign offset_done = (state_q == OFFSET) && (offset_cnt_q == cfg_i.offset);

    // With no offset, bit 0 sits on the word-select edge itself
    assign sample = cfg_i.en && ((ws_start && (cfg_i.offset == '0)) ||
                                 offset_done || (state_q == RUN));

    always_comb begin
        strobe_o.shift = sample;
        strobe_o.first = sample && (bit_cnt_q == '0);
        strobe_o.last  = sample && (bit_cnt_q == cfg_i.num_bits);
        strobe_o.clear = !cfg_i.en && (state_q != IDLE);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ws_start) begin
                    state_d = (cfg_i.offset == '0) ? RUN : OFFSET;
                end
            end
            OFFSET: begin
                if (offset_done) begin
                    state_d = RUN;
                end
            end
            default: begin
                state_d = state_q;
            end
        endcase
        // Disable wins from any state
        if (!cfg_i.en) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q      <= IDLE;
            offset_cnt_q <= '0;
            bit_cnt_q    <= '0;
        end else begin
            state_q <= state_d;

            // Counts edges since word select, equals the offset on bit 0
            if (state_d == OFFSET) begin
                offset_cnt_q <= offset_cnt_q + 1'b1;
            end else begin
                offset_cnt_q <= '0;
            end

            // Words follow back to back, so the counter just wraps
            if (!sample || strobe_o.last) begin
                bit_cnt_q <= '0;
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    a_bit_cnt_range: assert property (@(posedge sck_i) disable iff (!rstn_i)
        bit_cnt_q <= cfg_i.num_bits)
        else $error("bit counter beyond configured word length");

    a_first_last_apart: assert property (@(posedge sck_i) disable iff (!rstn_i)
        !(strobe_o.first && strobe_o.last))
        else $error("first and last strobe on the same edge");

endmodule

`default_nettype wire

//--- design/rx_deser.sv
`default_nettype none

module rx_deser #(
    parameter int DATA_W = rx_cfg_pkg::DATA_W
) (
    input  logic                     sck_i,
    input  logic                     rstn_i,
    input  logic                     sd_i,
    input  rx_cfg_pkg::rx_cfg_t      cfg_i,
    input  rx_data_pkg::bit_strobe_t strobe_i,
    output rx_data_pkg::sample_t     word_o,
    output logic                     done_o
);

    import rx_data_pkg::*;

    logic [DATA_W-1:0] sr_q;
    logic [DATA_W-1:0] sr_next;
    logic [DATA_W-1:0] aligned;
    logic [DATA_W-1:0] hold_q;
    logic              done_q;
    int                align_sh;

    always_comb begin
        if (cfg_i.lsb_first) begin
            // Enters at the top and walks down one place per bit
            sr_next = strobe_i.first ? {sd_i, {(DATA_W-1){1'b0}}}
                                     : {sd_i, sr_q[DATA_W-1:1]};
        end else begin
            sr_next = strobe_i.first ? {{(DATA_W-1){1'b0}}, sd_i}
                                     : {sr_q[DATA_W-2:0], sd_i};
        end
    end

    // An LSB-first word ends up in the top num_bits+1 places
    assign align_sh = DATA_W - 1 - int'(cfg_i.num_bits);
    assign aligned  = cfg_i.lsb_first ? (sr_next >> align_sh) : sr_next;

    always_ff @(posedge sck_i) begin
        if (strobe_i.clear) begin
            sr_q   <= '0;
            hold_q <= '0;
        end else if (strobe_i.shift) begin
            sr_q <= sr_next;
            if (strobe_i.last) begin
                hold_q <= aligned;
            end
        end
    end

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= strobe_i.last && !strobe_i.clear;
        end
    end

    assign word_o = sample_t'(hold_q);
    assign done_o = done_q;

    a_done_pulse: assert property (@(posedge sck_i) disable iff (!rstn_i)
        done_o |=> !done_o)
        else $error("done held longer than one cycle");

endmodule

`default_nettype wire

//--- design/rx_word_buffer.sv
`default_nettype none

module rx_word_buffer (
    input  logic                     sck_i,
    input  logic                     rstn_i,
    input  rx_cfg_pkg::rx_cfg_t      cfg_i,
    input  rx_data_pkg::bit_strobe_t strobe_i,
    input  rx_data_pkg::sample_t     ch0_word_i,
    input  rx_data_pkg::sample_t     ch1_word_i,
    input  logic                     done_i,
    input  logic                     data_ready_i,
    output rx_data_pkg::sample_t     data_o,
    output logic                     data_valid_o
);

    import rx_data_pkg::*;

    logic    ch0_pend_q;
    logic    ch1_pend_q;
    sample_t ch0_q;
    sample_t ch1_q;
    logic    xfer;

    // Channel 0 goes first, channel 1 only once channel 0 has left
    assign data_valid_o = ch0_pend_q || ch1_pend_q;
    assign data_o       = ch0_pend_q ? ch0_q : ch1_q;
    assign xfer         = data_valid_o && data_ready_i;

    always_ff @(posedge sck_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ch0_pend_q <= 1'b0;
            ch1_pend_q <= 1'b0;
        end else if (strobe_i.clear) begin
            ch0_pend_q <= 1'b0;
            ch1_pend_q <= 1'b0;
        end else if (done_i) begin
            // A new pair replaces anything still waiting
            ch0_pend_q <= 1'b1;
            ch1_pend_q <= cfg_i.two_ch;
        end else if (xfer) begin
            if (ch0_pend_q) begin
                ch0_pend_q <= 1'b0;
            end else begin
                ch1_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge sck_i) begin
        if (done_i && !strobe_i.clear) begin
            ch0_q <= ch0_word_i;
            ch1_q <= ch1_word_i;
        end
    end

    a_stall_stable: assert property (@(posedge sck_i) disable iff (!rstn_i)
        data_valid_o && !data_ready_i && !strobe_i.clear |=>
            data_valid_o && $stable(data_o))
        else $error("output changed while stalled");

endmodule

`default_nettype wire

//--- design/i2s_dsp_rx.sv
`default_nettype none

module i2s_dsp_rx #(
    parameter int DATA_W   = rx_cfg_pkg::DATA_W,
    parameter int OFFSET_W = rx_cfg_pkg::OFFSET_W
) (
    input  logic                          sck_i,
    input  logic                          rstn_i,
    input  logic                          i2s_ch0_i,
    input  logic                          i2s_ch1_i,
    input  logic                          i2s_ws_i,
    input  logic                          cfg_en_i,
    input  logic                          cfg_2ch_i,
    input  logic                          cfg_lsb_first_i,
    input  logic [rx_cfg_pkg::BITS_W-1:0] cfg_num_bits_i,
    input  logic [OFFSET_W-1:0]           cfg_slave_dsp_offset_i,
    output rx_data_pkg::sample_t          fifo_data_o,
    output logic                          fifo_data_valid_o,
    input  logic                          fifo_data_ready_i
);

    import rx_cfg_pkg::*;
    import rx_data_pkg::*;

    rx_cfg_t     cfg;
    bit_strobe_t strobe;
    sample_t     ch0_word;
    sample_t     ch1_word;
    logic        ch0_done;

    assign cfg = '{
        en:        cfg_en_i,
        two_ch:    cfg_2ch_i,
        lsb_first: cfg_lsb_first_i,
        num_bits:  cfg_num_bits_i,
        offset:    cfg_slave_dsp_offset_i
    };

    rx_ctrl #(
        .OFFSET_W (OFFSET_W)
    ) i_ctrl (
        .sck_i    (sck_i),
        .rstn_i   (rstn_i),
        .i2s_ws_i (i2s_ws_i),
        .cfg_i    (cfg),
        .strobe_o (strobe)
    );

    rx_deser #(
        .DATA_W (DATA_W)
    ) i_deser_ch0 (
        .sck_i    (sck_i),
        .rstn_i   (rstn_i),
        .sd_i     (i2s_ch0_i),
        .cfg_i    (cfg),
        .strobe_i (strobe),
        .word_o   (ch0_word),
        .done_o   (ch0_done)
    );

    // Completes on the same edge as channel 0
    rx_deser #(
        .DATA_W (DATA_W)
    ) i_deser_ch1 (
        .sck_i    (sck_i),
        .rstn_i   (rstn_i),
        .sd_i     (i2s_ch1_i),
        .cfg_i    (cfg),
        .strobe_i (strobe),
        .word_o   (ch1_word),
        .done_o   ()
    );

    rx_word_buffer i_buffer (
        .sck_i        (sck_i),
        .rstn_i       (rstn_i),
        .cfg_i        (cfg),
        .strobe_i     (strobe),
        .ch0_word_i   (ch0_word),
        .ch1_word_i   (ch1_word),
        .done_i       (ch0_done),
        .data_ready_i (fifo_data_ready_i),
        .data_o       (fifo_data_o),
        .data_valid_o (fifo_data_valid_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_i2s_dsp_rx.sv
`default_nettype none

module tb_i2s_dsp_rx;

    import rx_cfg_pkg::*;
    import rx_data_pkg::*;

    logic                sck_i;
    logic                rstn_i;
    logic                i2s_ch0_i;
    logic                i2s_ch1_i;
    logic                i2s_ws_i;
    logic                cfg_en_i;
    logic                cfg_2ch_i;
    logic                cfg_lsb_first_i;
    logic [BITS_W-1:0]   cfg_num_bits_i;
    logic [OFFSET_W-1:0] cfg_slave_dsp_offset_i;
    sample_t             fifo_data_o;
    logic                fifo_data_valid_o;
    logic                fifo_data_ready_i;

    // Expected words in output order
    logic [31:0] exp_q[$];
    int          err_cnt;
    int          check_cnt;
    int          test_num;
    int          test_err_start;
    int          cycle_cnt;
    int          cycle_limit;
    int          low_run;
    bit          stall_en;
    bit          hold_ready;
    bit          held;
    sample_t     held_data;

    i2s_dsp_rx #(
        .DATA_W   (DATA_W),
        .OFFSET_W (OFFSET_W)
    ) i_dut (
        .sck_i                  (sck_i),
        .rstn_i                 (rstn_i),
        .i2s_ch0_i              (i2s_ch0_i),
        .i2s_ch1_i              (i2s_ch1_i),
        .i2s_ws_i               (i2s_ws_i),
        .cfg_en_i               (cfg_en_i),
        .cfg_2ch_i              (cfg_2ch_i),
        .cfg_lsb_first_i        (cfg_lsb_first_i),
        .cfg_num_bits_i         (cfg_num_bits_i),
        .cfg_slave_dsp_offset_i (cfg_slave_dsp_offset_i),
        .fifo_data_o            (fifo_data_o),
        .fifo_data_valid_o      (fifo_data_valid_o),
        .fifo_data_ready_i      (fifo_data_ready_i)
    );

    initial sck_i = 1'b0;
    always #5 sck_i = !sck_i;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_cnt++;
        if (got !== expected) begin
            err_cnt++;
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    function automatic logic random_bit();
        return ($urandom() & 32'h1) != 32'h0;
    endfunction

    // One bit clock of serial data, ready stalls never longer than 2 cycles
    task automatic drive_edge(input logic ws, input logic d0, input logic d1);
        @(negedge sck_i);
        i2s_ws_i  = ws;
        i2s_ch0_i = d0;
        i2s_ch1_i = d1;
        if (hold_ready) begin
            fifo_data_ready_i = 1'b0;
        end else if (stall_en && low_run < 2 && random_bit()) begin
            fifo_data_ready_i = 1'b0;
            low_run++;
        end else begin
            fifo_data_ready_i = 1'b1;
            low_run = 0;
        end
    endtask

    task automatic run_frame(input int nbits, input bit lsb, input bit two, input int offset,
                             input int nwords, input int partial);
        logic [31:0] mask;
        logic [31:0] w0;
        logic [31:0] w1;
        int          idx;
        int          extra;
        cycle_limit += offset + nwords * nbits + partial + 64;
        mask = (nbits == 32) ? 32'hffff_ffff : ((32'h1 << nbits) - 32'h1);
        drive_edge(1'b0, 1'b0, 1'b0);
        cfg_en_i               = 1'b1;
        cfg_2ch_i              = two;
        cfg_lsb_first_i        = lsb;
        cfg_num_bits_i         = BITS_W'(nbits - 1);
        cfg_slave_dsp_offset_i = OFFSET_W'(offset);
        repeat (2) drive_edge(1'b0, random_bit(), random_bit());
        // Word select edge, then filler bits that must never show up
        for (int e = 0; e < offset; e++) begin
            drive_edge(e == 0, random_bit(), random_bit());
        end
        for (int w = 0; w < nwords; w++) begin
            w0 = $urandom() & mask;
            w1 = $urandom() & mask;
            // Words held back by ready are dropped by the disable
            if (!hold_ready) begin
                exp_q.push_back(w0);
                if (two) begin
                    exp_q.push_back(w1);
                end
            end
            for (int i = 0; i < nbits; i++) begin
                idx = lsb ? i : nbits - 1 - i;
                drive_edge((offset == 0) && (w == 0) && (i == 0), w0[idx], w1[idx]);
            end
        end
        // Word select is don't care here, the next word must not complete
        extra = 0;
        while (exp_q.size() != 0 || extra < partial) begin
            if (extra >= nbits) begin
                err_cnt++;
                $display("Output words did not drain before the next word completed");
                break;
            end
            drive_edge(random_bit(), random_bit(), random_bit());
            extra++;
        end
        // The held pair must still be waiting when the receiver is disabled
        if (hold_ready) begin
            check_value("fifo_data_valid_o", 32'(fifo_data_valid_o), 32'h1);
        end
        cfg_en_i = 1'b0;
        i2s_ws_i = 1'b0;
        repeat (3) drive_edge(1'b0, random_bit(), random_bit());
        check_value("fifo_data_valid_o", 32'(fifo_data_valid_o), 32'h0);
    endtask

    task automatic start_test();
        test_num++;
        test_err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("Test %0d: %0d expected words never appeared", test_num, exp_q.size());
            exp_q.delete();
        end
        $display("Test %0d %s: %0d errors", test_num, name, err_cnt - test_err_start);
    endtask

    // Output monitor, also checks that a stalled item holds
    always @(posedge sck_i) begin
        if (rstn_i) begin
            if (held) begin
                check_value("fifo_data_valid_o", 32'(fifo_data_valid_o), 32'h1);
                check_value("fifo_data_o", fifo_data_o, held_data);
            end
            if (fifo_data_valid_o && fifo_data_ready_i) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Unexpected output word 0x%08h with nothing expected", fifo_data_o);
                end else begin
                    check_value("fifo_data_o", fifo_data_o, exp_q.pop_front());
                end
            end
            // Only an enabled receiver keeps a stalled item
            held      = fifo_data_valid_o && !fifo_data_ready_i && cfg_en_i;
            held_data = fifo_data_o;
        end
    end

    always @(posedge sck_i) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int lens[4];
        lens = '{8, 12, 24, 32};
        void'($urandom(53726));
        rstn_i                 = 1'b0;
        i2s_ch0_i              = 1'b0;
        i2s_ch1_i              = 1'b0;
        i2s_ws_i               = 1'b0;
        cfg_en_i               = 1'b0;
        cfg_2ch_i              = 1'b0;
        cfg_lsb_first_i        = 1'b0;
        cfg_num_bits_i         = '0;
        cfg_slave_dsp_offset_i = '0;
        fifo_data_ready_i      = 1'b1;
        err_cnt                = 0;
        check_cnt              = 0;
        test_num               = 0;
        cycle_cnt              = 0;
        cycle_limit            = 32;
        low_run                = 0;
        stall_en               = 1'b0;
        hold_ready             = 1'b0;
        held                   = 1'b0;
        repeat (2) @(posedge sck_i);
        @(negedge sck_i);
        rstn_i = 1'b1;
        check_value("fifo_data_valid_o", 32'(fifo_data_valid_o), 32'h0);

        start_test();
        run_frame(16, 1'b0, 1'b1, 0, 6, 0);
        end_test("msb first two channels");

        start_test();
        for (int k = 0; k < 4; k++) begin
            run_frame(lens[k], 1'b1, 1'b1, 0, 4, 0);
        end
        end_test("lsb first lengths");

        start_test();
        run_frame(16, 1'b0, 1'b1, $urandom_range(200, 1), 5, 0);
        end_test("frame offset");

        start_test();
        run_frame(12, 1'b0, 1'b0, $urandom_range(8, 0), 6, 0);
        end_test("single channel");

        start_test();
        stall_en = 1'b1;
        for (int k = 0; k < 3; k++) begin
            run_frame($urandom_range(32, 8), random_bit(), 1'b1, $urandom_range(20, 0), 8, 0);
        end
        stall_en = 1'b0;
        end_test("ready stalls");

        // Disable part way into the third word, then while a pair waits, then a clean frame
        start_test();
        run_frame(16, 1'b0, 1'b1, 3, 2, 10);
        hold_ready = 1'b1;
        run_frame(16, 1'b0, 1'b1, $urandom_range(10, 0), 1, 3);
        hold_ready = 1'b0;
        run_frame(16, 1'b1, 1'b1, $urandom_range(30, 1), 3, 0);
        end_test("disable mid frame");

        $display("Checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/rx_cfg_pkg.sv
design/rx_data_pkg.sv
design/rx_ctrl.sv
design/rx_deser.sv
design/rx_word_buffer.sv
design/i2s_dsp_rx.sv
testbench/tb_i2s_dsp_rx.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator, fail if the log reports errors
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_i2s_dsp_rx \
    --Mdir obj_dir -o tb_i2s_dsp_rx

./obj_dir/tb_i2s_dsp_rx > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
